// File: design/fibCfgPkg.sv
`default_nettype none

package fibCfgPkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath sizing
    ////////////////////////////////////////////////////////////////////////////

    // one series value
    localparam int WORD_W = 16;
    // term index of a run request
    localparam int COUNT_W = 6;
    // job tag carried from command to result
    localparam int TAG_W = 4;

    // lane array
    localparam int NUM_LANES = 4;
    // lane index, NUM_LANES is a power of two
    localparam int LANE_W = 2;
    // register file entries per lane
    localparam int REG_COUNT = 4;

    ////////////////////////////////////////////////////////////////////////////
    // flow control
    ////////////////////////////////////////////////////////////////////////////

    // queue depth equals upstream starting credits
    localparam int CMD_DEPTH = 2;
    localparam int RES_CREDITS_MAX = 4;
    localparam int CREDIT_W = 3;

endpackage

`default_nettype wire

// File: design/fibMsgPkg.sv
`default_nettype none

package fibMsgPkg;

    import fibCfgPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // command stream
    ////////////////////////////////////////////////////////////////////////////

    // what the payload holds
    typedef enum logic {
        CMD_SEED = 1'b0,
        CMD_RUN  = 1'b1
    } cmdKindE;

    // seedA is term 0 and seedB is term 1
    typedef struct packed {
        logic [WORD_W-1:0] seedA;
        logic [WORD_W-1:0] seedB;
    } seedPayloadT;

    // count and tag sit in the low bits
    typedef struct packed {
        logic [2*WORD_W-COUNT_W-TAG_W-1:0] pad;
        logic [COUNT_W-1:0]                count;
        logic [TAG_W-1:0]                  tag;
    } runPayloadT;

    // same 32 bits, read by kind
    typedef union packed {
        seedPayloadT seeds;
        runPayloadT  run;
    } cmdPayloadU;

    typedef struct packed {
        cmdKindE    kind;
        cmdPayloadU payload;
    } cmdT;

    ////////////////////////////////////////////////////////////////////////////
    // lane traffic
    ////////////////////////////////////////////////////////////////////////////

    // run request merged with the seeds in force
    typedef struct packed {
        logic [WORD_W-1:0]  seedA;
        logic [WORD_W-1:0]  seedB;
        logic [COUNT_W-1:0] count;
        logic [TAG_W-1:0]   tag;
    } laneJobT;

    // overflow is set if any add carried out
    typedef struct packed {
        logic [WORD_W-1:0] value;
        logic              overflow;
        logic [TAG_W-1:0]  tag;
    } laneResultT;

    // result as it leaves the collector
    typedef struct packed {
        laneResultT        payload;
        logic [LANE_W-1:0] lane;
    } resultT;

    typedef enum logic {
        ALU_ADD  = 1'b0,
        ALU_PASS = 1'b1
    } aluOpE;

endpackage

`default_nettype wire

// File: design/fibAlu.sv
`default_nettype none

module fibAlu (
    input  wire logic                          clk,
    input  wire logic                          arstN,
    input  wire logic                          clear,
    input  wire fibMsgPkg::aluOpE              op,
    input  wire logic [fibCfgPkg::WORD_W-1:0]  operandA,
    input  wire logic [fibCfgPkg::WORD_W-1:0]  operandB,
    output logic [fibCfgPkg::WORD_W-1:0]       sum,
    output logic                               carryFlag
);

    import fibCfgPkg::*;
    import fibMsgPkg::*;

    // one extra bit keeps the carry out
    logic [WORD_W:0] addWide;
    logic            carry;

    assign addWide = {1'b0, operandA} + {1'b0, operandB};

    always_comb begin
        if (op == ALU_ADD) begin
            sum   = addWide[WORD_W-1:0];
            carry = addWide[WORD_W];
        end else begin
            // pass forwards operand B
            sum   = operandB;
            carry = 1'b0;
        end
    end

    // sticky carry, held until the next clear
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            carryFlag <= 1'b0;
        end else if (clear) begin
            carryFlag <= 1'b0;
        end else if (carry) begin
            carryFlag <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/fibLane.sv
`default_nettype none

module fibLane (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire logic                 jobValid,
    input  wire fibMsgPkg::laneJobT   job,
    output logic                      laneIdle,
    output logic                      doneValid,
    output fibMsgPkg::laneResultT     done,
    input  wire logic                 take
);

    import fibCfgPkg::*;
    import fibMsgPkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_A,
        ST_LOAD_B,
        ST_ITER,
        ST_HOLD
    } laneStateE;

    laneStateE          state;
    laneJobT            jobQ;
    // adds still to do
    logic [COUNT_W-1:0] remain;
    logic [WORD_W-1:0]  regFile [REG_COUNT];
    aluOpE              aluOp;
    logic [WORD_W-1:0]  aluB;
    logic [WORD_W-1:0]  aluSum;
    logic               aluClear;
    logic               carryFlag;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    // count 0 skips load B, count 1 skips iterate
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= ST_IDLE;
            remain <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (jobValid) begin
                        state  <= ST_LOAD_A;
                        remain <= job.count;
                    end
                end
                ST_LOAD_A: state <= (remain == '0) ? ST_HOLD : ST_LOAD_B;
                ST_LOAD_B, ST_ITER: begin
                    remain <= remain - 1'b1;
                    state  <= (remain == COUNT_W'(1)) ? ST_HOLD : ST_ITER;
                end
                // result waits for the collector
                ST_HOLD: if (take) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && jobValid) begin
            jobQ <= job;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    // muxes stand in for the bus buffers
    always_comb begin
        aluOp = ALU_PASS;
        aluB  = regFile[1];
        case (state)
            ST_LOAD_A: aluB = jobQ.seedA;
            ST_LOAD_B: aluB = jobQ.seedB;
            ST_ITER:   aluOp = ALU_ADD;
            default:   aluOp = ALU_PASS;
        endcase
    end

    // flag restarts with every job
    assign aluClear = (state == ST_LOAD_A);

    fibAlu fibAlu_inst (
        .clk       (clk),
        .arstN     (arstN),
        .clear     (aluClear),
        .op        (aluOp),
        .operandA  (regFile[0]),
        .operandB  (aluB),
        .sum       (aluSum),
        .carryFlag (carryFlag)
    );

    // entries 0 and 1 hold the newest pair of terms
    always_ff @(posedge clk) begin
        case (state)
            ST_LOAD_A: regFile[0] <= aluSum;
            ST_LOAD_B: regFile[1] <= aluSum;
            ST_ITER: begin
                regFile[2] <= aluSum;
                regFile[0] <= regFile[1];
                regFile[1] <= aluSum;
            end
            default: ;
        endcase
    end

    assign laneIdle  = (state == ST_IDLE);
    assign doneValid = (state == ST_HOLD);

    always_comb begin
        // entry 2 has the newest sum once any add has run
        if (jobQ.count == '0) begin
            done.value = regFile[0];
        end else if (jobQ.count == COUNT_W'(1)) begin
            done.value = regFile[1];
        end else begin
            done.value = regFile[2];
        end
        done.overflow = carryFlag;
        done.tag      = jobQ.tag;
    end

endmodule

`default_nettype wire

// File: design/fibDispatcher.sv
`default_nettype none

module fibDispatcher (
    input  wire logic                             clk,
    input  wire logic                             arstN,
    input  wire logic                             cmdValid,
    input  wire fibMsgPkg::cmdT                   cmd,
    output logic                                  cmdCredit,
    input  wire logic [fibCfgPkg::NUM_LANES-1:0]  laneIdle,
    output logic [fibCfgPkg::NUM_LANES-1:0]       jobValid,
    output fibMsgPkg::laneJobT                    job
);

    import fibCfgPkg::*;
    import fibMsgPkg::*;

    // command queue
    cmdT                            queueMem [CMD_DEPTH];
    logic [$clog2(CMD_DEPTH)-1:0]   wrPtr;
    logic [$clog2(CMD_DEPTH)-1:0]   rdPtr;
    logic [$clog2(CMD_DEPTH+1)-1:0] fill;
    cmdT                            headCmd;
    logic                           headValid;
    logic                           deq;
    // lane choice
    logic [NUM_LANES-1:0]           lowIdle;
    // seeds in force
    logic [WORD_W-1:0]              seedA;
    logic [WORD_W-1:0]              seedB;

    ////////////////////////////////////////////////////////////////////////////
    // queue
    ////////////////////////////////////////////////////////////////////////////

    // sender holds a credit per word, so never full on write
    always_ff @(posedge clk) begin
        if (cmdValid) begin
            queueMem[wrPtr] <= cmd;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (cmdValid) begin
                wrPtr <= (wrPtr == CMD_DEPTH - 1) ? '0 : wrPtr + 1'b1;
            end
            if (deq) begin
                rdPtr <= (rdPtr == CMD_DEPTH - 1) ? '0 : rdPtr + 1'b1;
            end
            // occupancy
            case ({cmdValid, deq})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    assign headCmd   = queueMem[rdPtr];
    assign headValid = (fill != '0);

    ////////////////////////////////////////////////////////////////////////////
    // head decode
    ////////////////////////////////////////////////////////////////////////////

    // isolate lowest set bit of the idle mask
    assign lowIdle = laneIdle & (~laneIdle + 1'b1);

    // seeds always leave, runs wait for a free lane
    assign deq       = headValid && ((headCmd.kind == CMD_SEED) || (laneIdle != '0));
    assign cmdCredit = deq;
    assign jobValid  = (deq && (headCmd.kind == CMD_RUN)) ? lowIdle : '0;

    // job bus shared by all lanes
    always_comb begin
        job.seedA = seedA;
        job.seedB = seedB;
        job.count = headCmd.payload.run.count;
        job.tag   = headCmd.payload.run.tag;
    end

    // zero seeds until the first seed command
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            seedA <= '0;
            seedB <= '0;
        end else if (deq && (headCmd.kind == CMD_SEED)) begin
            seedA <= headCmd.payload.seeds.seedA;
            seedB <= headCmd.payload.seeds.seedB;
        end
    end

endmodule

`default_nettype wire

// File: design/fibCollector.sv
`default_nettype none

module fibCollector (
    input  wire logic                             clk,
    input  wire logic                             arstN,
    input  wire logic [fibCfgPkg::NUM_LANES-1:0]  doneValid,
    input  wire fibMsgPkg::laneResultT            done [fibCfgPkg::NUM_LANES],
    output logic [fibCfgPkg::NUM_LANES-1:0]       take,
    input  wire logic                             resCredit,
    output logic                                  resultValid,
    output fibMsgPkg::resultT                     result
);

    import fibCfgPkg::*;
    import fibMsgPkg::*;

    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] creditsNext;
    // next lane to look at first
    logic [LANE_W-1:0]   rrPtr;
    logic [LANE_W-1:0]   pick;
    logic                found;
    logic                freeCredit;

    ////////////////////////////////////////////////////////////////////////////
    // credits
    ////////////////////////////////////////////////////////////////////////////

    // a credit is spent in the cycle its result is on the bus
    // so one is already promised while resultValid is high
    assign freeCredit = (credits > CREDIT_W'(resultValid));

    always_comb begin
        creditsNext = credits;
        if (resultValid) begin
            creditsNext = creditsNext - 1'b1;
        end
        // saturate
        if (resCredit && (creditsNext != CREDIT_W'(RES_CREDITS_MAX))) begin
            creditsNext = creditsNext + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // round robin
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [LANE_W-1:0] cand;
        found = 1'b0;
        pick  = rrPtr;
        cand  = rrPtr;
        for (int i = 0; i < NUM_LANES; i++) begin
            // wraps at LANE_W bits
            cand = rrPtr + LANE_W'(i);
            if (!found && doneValid[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    always_comb begin
        take = '0;
        if (found && freeCredit) begin
            take[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credits     <= '0;
            rrPtr       <= '0;
            resultValid <= 1'b0;
        end else begin
            credits     <= creditsNext;
            resultValid <= |take;
            // resume after the lane just served
            if (|take) rrPtr <= pick + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (|take) begin
            result.payload <= done[pick];
            result.lane    <= pick;
        end
    end

endmodule

`default_nettype wire

// File: design/fibTop.sv
`default_nettype none

module fibTop (
    input  wire logic            clk,
    input  wire logic            arstN,
    input  wire logic            cmdValid,
    input  wire fibMsgPkg::cmdT  cmd,
    output logic                 cmdCredit,
    output logic                 resultValid,
    output fibMsgPkg::resultT    result,
    input  wire logic            resCredit
);

    import fibCfgPkg::*;
    import fibMsgPkg::*;

    // dispatcher to lanes
    logic [NUM_LANES-1:0] laneIdle;
    logic [NUM_LANES-1:0] jobValid;
    laneJobT              job;
    // lanes to collector
    logic [NUM_LANES-1:0] doneValid;
    laneResultT           done [NUM_LANES];
    logic [NUM_LANES-1:0] take;

    fibDispatcher fibDispatcher_inst (
        .clk       (clk),
        .arstN     (arstN),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .cmdCredit (cmdCredit),
        .laneIdle  (laneIdle),
        .jobValid  (jobValid),
        .job       (job)
    );

    ////////////////////////////////////////////////////////////////////////////
    // lanes
    ////////////////////////////////////////////////////////////////////////////

    // every lane sees the shared job bus, jobValid picks one
    for (genvar laneIdx = 0; laneIdx < NUM_LANES; laneIdx++) begin : gLane
        fibLane fibLane_inst (
            .clk       (clk),
            .arstN     (arstN),
            .jobValid  (jobValid[laneIdx]),
            .job       (job),
            .laneIdle  (laneIdle[laneIdx]),
            .doneValid (doneValid[laneIdx]),
            .done      (done[laneIdx]),
            .take      (take[laneIdx])
        );
    end

    fibCollector fibCollector_inst (
        .clk         (clk),
        .arstN       (arstN),
        .doneValid   (doneValid),
        .done        (done),
        .take        (take),
        .resCredit   (resCredit),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

`default_nettype wire

// File: dv/fibTop_chk.sv
`default_nettype none

module fibTop_chk (
    input  wire logic                             clk,
    input  wire logic                             arstN,
    input  wire logic                             resultValid,
    input  wire logic [fibCfgPkg::CREDIT_W-1:0]   credits,
    input  wire logic [fibCfgPkg::NUM_LANES-1:0]  jobValid,
    input  wire logic [fibCfgPkg::NUM_LANES-1:0]  laneIdle
);

    timeunit 1ns;
    timeprecision 1ps;

    import fibCfgPkg::*;

    // fired assertions, polled by the testbench every cycle
    int unsigned failCount;

    initial begin
        failCount = 0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // downstream credits
    ////////////////////////////////////////////////////////////////////////////

    // a result spends a credit that the collector already holds
    resultNeedsCredit: assert property (@(posedge clk) disable iff (!arstN)
        resultValid |-> (credits != '0))
        else begin
            $error("resultValid while the collector holds no credit");
            failCount++;
        end

    // counter saturates
    creditBound: assert property (@(posedge clk) disable iff (!arstN)
        credits <= CREDIT_W'(RES_CREDITS_MAX))
        else begin
            $error("collector credit count above its maximum");
            failCount++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // job issue
    ////////////////////////////////////////////////////////////////////////////

    // busy lane never gets a job
    jobToIdleLane: assert property (@(posedge clk) disable iff (!arstN)
        (jobValid & ~laneIdle) == '0)
        else begin
            $error("jobValid sent to a busy lane");
            failCount++;
        end

    // shared job bus, one lane per cycle
    oneJobPerCycle: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0(jobValid))
        else begin
            $error("more than one jobValid in a cycle");
            failCount++;
        end

endmodule

bind fibTop fibTop_chk fibTop_chk_inst (
    .clk         (clk),
    .arstN       (arstN),
    .resultValid (resultValid),
    .credits     (fibCollector_inst.credits),
    .jobValid    (jobValid),
    .laneIdle    (laneIdle)
);

`default_nettype wire

// File: dv/fibTb.sv
`default_nettype none

module fibTb;

    timeunit 1ns;
    timeprecision 1ps;

    import fibCfgPkg::*;
    import fibMsgPkg::*;

    localparam logic [31:0] LCG_SEED = 32'h56fd_95c3;
    localparam int NUM_CMDS       = 60;
    localparam int MIX_END        = 39;
    localparam int MAX_COUNT      = 40;
    localparam int HOLD_CYCLES    = 400;
    localparam int HOLD_CMDS      = 12;
    localparam int QUIET_CYCLES   = 100;
    localparam int DRAIN_MARGIN   = 1000;
    localparam int TIMEOUT_CYCLES =
        NUM_CMDS * (MAX_COUNT + 2 + NUM_LANES + 10) + HOLD_CYCLES + DRAIN_MARGIN;
    localparam int NUM_TAGS       = 2 ** TAG_W;

    logic   clk;
    logic   arstN;
    logic   cmdValid;
    cmdT    cmd;
    logic   cmdCredit;
    logic   resultValid;
    resultT result;
    logic   resCredit;

    logic [31:0]       lcgState;
    // upstream sender view
    int                upCredits;
    int                cmdsSent;
    int                cmdCreditCount;
    int                lastCreditCycle;
    // commands in the order the DUT queue holds them
    cmdT               sentQueue [$];
    // downstream grant pacing
    logic              creditsOn;
    int                creditGap;
    // scoreboard, indexed by tag
    logic [WORD_W-1:0] expValue [NUM_TAGS];
    logic              expOverflow [NUM_TAGS];
    logic [LANE_W-1:0] expLane [NUM_TAGS];
    logic              pending [NUM_TAGS];
    // lanes holding a job, from dispatch until the result leaves
    logic              laneBusy [NUM_LANES];
    int                pendingCount;
    int                tagPtr;
    int                resultsSeen;
    int                overflowSeen;
    int                cleanSeen;
    int                maxBusy;
    int                cycleCount;
    // seeds the DUT will use for the next run
    logic [WORD_W-1:0] modelSeedA;
    logic [WORD_W-1:0] modelSeedB;

    fibTop fibTop_inst (
        .clk         (clk),
        .arstN       (arstN),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .cmdCredit   (cmdCredit),
        .resultValid (resultValid),
        .result      (result),
        .resCredit   (resCredit)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic mismatch(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        $display("FAILED %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randCount();
        return int'((nextRand() >> 8) % (MAX_COUNT + 1));
    endfunction

    function automatic logic [WORD_W-1:0] randWord();
        logic [31:0] r;
        r = nextRand();
        return r[23:8];
    endfunction

    // term count of the series, carry out of any add in the top bit
    function automatic logic [WORD_W:0] fibRef(input logic [WORD_W-1:0] a,
                                               input logic [WORD_W-1:0] b,
                                               input int count);
        logic [WORD_W-1:0] prev;
        logic [WORD_W-1:0] cur;
        logic [WORD_W:0]   total;
        logic              carried;
        prev    = a;
        cur     = b;
        carried = 1'b0;
        if (count == 0) begin
            return {1'b0, a};
        end
        for (int i = 2; i <= count; i++) begin
            total   = {1'b0, prev} + {1'b0, cur};
            carried = carried | total[WORD_W];
            prev    = cur;
            cur     = total[WORD_W-1:0];
        end
        return {carried, cur};
    endfunction

    // a run goes to the lowest lane without a job
    task automatic allocLane(input logic [TAG_W-1:0] tag);
        logic found;
        found = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (!found && !laneBusy[i]) begin
                found        = 1'b1;
                laneBusy[i]  = 1'b1;
                expLane[tag] = LANE_W'(i);
            end
        end
        assert (found)
            else abortRun("run command left the queue while every lane was busy");
    endtask

    task automatic checkResult();
        logic [TAG_W-1:0] tag;
        tag = result.payload.tag;
        assert (pending[tag])
            else abortRun("result arrived with a tag that has no job in flight");
        assert (result.payload.value == expValue[tag])
            else mismatch("result.payload.value", expValue[tag], result.payload.value);
        assert (result.payload.overflow == expOverflow[tag])
            else mismatch("result.payload.overflow", expOverflow[tag],
                          result.payload.overflow);
        assert (result.lane == expLane[tag])
            else mismatch("result.lane", expLane[tag], result.lane);
        laneBusy[expLane[tag]] = 1'b0;
        pending[tag] = 1'b0;
        pendingCount--;
        resultsSeen++;
        if (expOverflow[tag]) begin
            overflowSeen++;
        end else begin
            cleanSeen++;
        end
    endtask

    // one falling edge, outputs sampled before any input changes
    task automatic nextCycle();
        int  busy;
        cmdT dispatched;
        @(negedge clk);
        cycleCount++;
        assert (cycleCount < TIMEOUT_CYCLES)
            else abortRun("timeout, the run did not finish within its cycle limit");
        assert (fibTop_inst.fibTop_chk_inst.failCount == 0)
            else abortRun("a protocol assertion in fibTop_chk fired");
        busy = $countones(~fibTop_inst.laneIdle);
        if (busy > maxBusy) begin
            maxBusy = busy;
        end
        // results first, a lane freed here can take a run this cycle
        if (resultValid) begin
            checkResult();
        end
        if (cmdCredit) begin
            upCredits++;
            cmdCreditCount++;
            lastCreditCycle = cycleCount;
        end
        assert (upCredits <= CMD_DEPTH)
            else mismatch("upCredits", CMD_DEPTH, upCredits);
        // queue head leaves in send order
        if (cmdCredit) begin
            dispatched = sentQueue.pop_front();
            if (dispatched.kind == CMD_RUN) begin
                allocLane(dispatched.payload.run.tag);
            end
        end
        // random gaps between grants
        if (!creditsOn) begin
            resCredit = 1'b0;
        end else if (creditGap == 0) begin
            resCredit = 1'b1;
            creditGap = int'((nextRand() >> 12) % 4);
        end else begin
            resCredit = 1'b0;
            creditGap--;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // command stimulus
    ////////////////////////////////////////////////////////////////////////////

    // waits for an upstream credit, one cycle of cmdValid
    task automatic pushCmd(input cmdT c);
        while (upCredits == 0) begin
            nextCycle();
        end
        cmdValid = 1'b1;
        cmd      = c;
        upCredits--;
        cmdsSent++;
        sentQueue.push_back(c);
        nextCycle();
        cmdValid = 1'b0;
    endtask

    task automatic requestRun(input int count);
        logic [WORD_W:0]  refVal;
        logic [TAG_W-1:0] tag;
        logic             found;
        cmdT              c;
        found = 1'b0;
        tag   = '0;
        // rotate through free tags
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (!found && !pending[TAG_W'(tagPtr + i)]) begin
                found = 1'b1;
                tag   = TAG_W'(tagPtr + i);
            end
        end
        assert (found) else abortRun("no free tag left for a run command");
        tagPtr           = int'(tag) + 1;
        refVal           = fibRef(modelSeedA, modelSeedB, count);
        expValue[tag]    = refVal[WORD_W-1:0];
        expOverflow[tag] = refVal[WORD_W];
        pending[tag]     = 1'b1;
        pendingCount++;
        c                   = '0;
        c.kind              = CMD_RUN;
        c.payload.run.count = COUNT_W'(count);
        c.payload.run.tag   = tag;
        pushCmd(c);
    endtask

    // queue order keeps earlier runs on the old seeds
    task automatic requestSeeds(input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b);
        cmdT c;
        modelSeedA            = a;
        modelSeedB            = b;
        c                     = '0;
        c.kind                = CMD_SEED;
        c.payload.seeds.seedA = a;
        c.payload.seeds.seedB = b;
        pushCmd(c);
    endtask

    // about one seed command in five
    task automatic randomTraffic();
        if (((nextRand() >> 16) % 5) == 0) begin
            requestSeeds(randWord(), randWord());
        end else begin
            requestRun(randCount());
        end
    endtask

    task automatic holdBackPressure();
        int holdStart;
        int resultsBefore;
        int holdSent;
        creditsOn     = 1'b0;
        resCredit     = 1'b0;
        holdStart     = cycleCount;
        resultsBefore = resultsSeen;
        holdSent      = 0;
        while (cycleCount - holdStart < HOLD_CYCLES) begin
            if ((upCredits > 0) && (holdSent < HOLD_CMDS)) begin
                requestRun(randCount());
                holdSent++;
            end else begin
                nextCycle();
            end
        end
        // only credits granted before the hold may drain
        assert (resultsSeen - resultsBefore <= RES_CREDITS_MAX)
            else abortRun("results kept coming after downstream credits were withheld");
        assert (holdSent < HOLD_CMDS)
            else abortRun("upstream credits did not stop under back-pressure");
        assert (cycleCount - lastCreditCycle >= QUIET_CYCLES)
            else abortRun("cmdCredit still pulsing late in the back-pressure window");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk             = 1'b0;
        arstN           = 1'b0;
        cmdValid        = 1'b0;
        cmd             = '0;
        resCredit       = 1'b0;
        lcgState        = LCG_SEED;
        upCredits       = CMD_DEPTH;
        cmdsSent        = 0;
        cmdCreditCount  = 0;
        lastCreditCycle = 0;
        creditsOn       = 1'b0;
        creditGap       = 0;
        pendingCount    = 0;
        tagPtr          = 0;
        resultsSeen     = 0;
        overflowSeen    = 0;
        cleanSeen       = 0;
        maxBusy         = 0;
        cycleCount      = 0;
        modelSeedA      = '0;
        modelSeedB      = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            pending[i] = 1'b0;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            laneBusy[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        arstN     = 1'b1;
        creditsOn = 1'b1;

        // reset seeds are zero
        requestRun(0);
        requestRun(1);
        requestRun(2);
        requestRun(7);
        // counts 0 and 1 pick seedA and seedB
        requestSeeds(randWord(), randWord());
        requestRun(0);
        requestRun(1);
        requestRun(randCount());
        // term 23 is 46368, term 24 wraps
        requestSeeds(16'h0001, 16'h0001);
        requestRun(23);
        requestRun(24);
        // bursts with seeds mixed in
        while (cmdsSent < MIX_END) begin
            randomTraffic();
        end
        holdBackPressure();
        creditsOn = 1'b1;
        while (cmdsSent < NUM_CMDS) begin
            randomTraffic();
        end
        // all runs back, then queued seeds leave one per cycle
        while (pendingCount != 0) begin
            nextCycle();
        end
        repeat (CMD_DEPTH) begin
            nextCycle();
        end

        assert (cmdCreditCount == cmdsSent)
            else mismatch("cmdCredit pulse count", cmdsSent, cmdCreditCount);
        assert (maxBusy == NUM_LANES)
            else mismatch("peak busy lanes", NUM_LANES, maxBusy);
        assert ((overflowSeen > 0) && (cleanSeen > 0))
            else abortRun("results did not include both overflow and clean runs");

        if (fibTop_inst.fibTop_chk_inst.failCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: src.f
design/fibCfgPkg.sv
design/fibMsgPkg.sv
design/fibAlu.sv
design/fibLane.sv
design/fibDispatcher.sv
design/fibCollector.sv
design/fibTop.sv
dv/fibTop_chk.sv
dv/fibTb.sv
